// ==== common/ks10Pkg.sv ====
// KS10 words are numbered 0 to 35 with bit 0 as the most significant bit
package ks10Pkg;

   ////////////////////////////////////////
   // Data types
   ////////////////////////////////////////

   typedef logic [0:35] word_t;         // One KS10 word

   // Priority level
   // 0 means no level, 1 is highest, 7 is lowest
   typedef logic [0:2]  level_t;

   ////////////////////////////////////////
   // Micro-operation function codes
   ////////////////////////////////////////

   // Stand-ins for the microcode actions that reach this slice
   typedef enum logic [0:2] {
      opNOP       = 3'd0,               // Idle
      opWRAPR     = 3'd1,               // Write APR flags, enables, PIA
      opWRPI      = 3'd2,               // Write PI system
      opPIACK     = 3'd3,               // Take requested level
      opPIDISMISS = 3'd4,               // Drop current level
      opHALT      = 3'd5,               // Halt the CPU
      opCLRCONT   = 3'd6,               // Clear CONT and EXEC
      opBUSRD     = 3'd7                // Start a bus read
   } opFunc_t;

endpackage : ks10Pkg

// ==== common/aprPkg.sv ====
// Bit positions use KS10 numbering, so a lower number is a more significant bit
package aprPkg;

   // Flag vector, one bit per APR flag
   typedef logic [0:4] flags_t;

   localparam int flagCSLO  = 0;        // Interrupt to console
   localparam int flagPWR   = 1;        // Power fail
   localparam int flagNXM   = 2;        // Non-existent memory
   localparam int flagTIMER = 3;        // Interval timer
   localparam int flagCSLI  = 4;        // Interrupt from console

   ////////////////////////////////////////
   // aprFLAGS layout, bits 22 to 35
   ////////////////////////////////////////

   localparam int aprFlagsFirst = 22;
   localparam int aprFlagsLast  = 35;
   localparam int aprEnFirst    = 22;   // Flag enables
   localparam int aprEnLast     = 26;
   localparam int aprFlFirst    = 27;   // Flags
   localparam int aprFlLast     = 31;
   localparam int aprIntrBit    = 32;   // Interrupt request
   localparam int aprPiaFirst   = 33;   // PI assignment
   localparam int aprPiaLast    = 35;

   ////////////////////////////////////////
   // WRAPR command word
   ////////////////////////////////////////

   localparam int wraprEN       = 20;   // Enable selected flags
   localparam int wraprDIS      = 21;   // Disable selected flags
   localparam int wraprCLR      = 22;   // Clear selected flags
   localparam int wraprSET      = 23;   // Set selected flags
   localparam int wraprSelFirst = 27;   // Flag select, same order as flags_t
   localparam int wraprSelLast  = 31;
   localparam int wraprPiaFirst = 33;   // New PIA
   localparam int wraprPiaLast  = 35;

   ////////////////////////////////////////
   // WRPI command word
   ////////////////////////////////////////

   localparam int wrpiCLRACT   = 23;    // Empty the active set
   localparam int wrpiLVLOFF   = 25;    // Clear selected level enables
   localparam int wrpiLVLON    = 26;    // Set selected level enables
   localparam int wrpiSYSOFF   = 27;    // PI system off
   localparam int wrpiSYSON    = 28;    // PI system on
   localparam int wrpiSelFirst = 29;    // Level select, bit 29 is level 1
   localparam int wrpiSelLast  = 35;

endpackage : aprPkg

// ==== common/uopIf.sv ====
// Strobe is a single-cycle pulse and each block decodes only its own codes
interface uopIf;

   import ks10Pkg::*;

   logic    opStb;                      // Micro-op strobe
   opFunc_t opFunc;                     // Function code
   word_t   opData;                     // Command word

   // Issuing side, stands in for the microsequencer
   modport seq (
      output opStb,
      output opFunc,
      output opData
   );

   // Receiving side, one per functional block
   modport blk (
      input  opStb,
      input  opFunc,
      input  opData
   );

endinterface : uopIf

// ==== pi/piCfg.sv ====
// Only WRPI touches this state and system-off wins over system-on in one word
module piCfg (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   uopIf.blk    uop,                    // Micro-op strobe
   output logic piOn,                   // PI system on
   output logic [1:7] piEnable          // Level enables
);

   import ks10Pkg::*;
   import aprPkg::*;

   logic       wrpi;                    // WRPI strobe
   logic [1:7] lvlSel;                  // Selected levels
   logic [1:7] enNext;

   assign wrpi   = uop.opStb && (uop.opFunc == opWRPI);
   assign lvlSel = uop.opData[wrpiSelFirst:wrpiSelLast];

   // Level enable update, clear applied after set
   always_comb begin
      enNext = piEnable;
      if (uop.opData[wrpiLVLON])
         enNext = enNext | lvlSel;
      if (uop.opData[wrpiLVLOFF])
         enNext = enNext & ~lvlSel;
   end

   always_ff @(posedge clkT) begin
      if (rst) begin
         piOn     <= 1'b0;
         piEnable <= '0;
      end else if (wrpi) begin
         piEnable <= enNext;
         if (uop.opData[wrpiSYSOFF])
            piOn <= 1'b0;               // Off has priority
         else if (uop.opData[wrpiSYSON])
            piOn <= 1'b1;
      end
   end

endmodule : piCfg

// ==== pi/pi.sv ====
// Outputs are registered, so a new request shows one clock after it arrives
module pi (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   uopIf.blk    uop,                    // Micro-op strobe
   input  logic piOn,                   // PI system on
   input  logic [1:7] piEnable,         // Level enables
   input  logic [1:7] aprINTR,          // APR request
   input  logic [1:7] ubaINTR,          // Unibus request
   output logic piINTR,                 // Interrupt the CPU
   output ks10Pkg::level_t piREQPRI,    // Requested priority
   output ks10Pkg::level_t piCURPRI     // Current priority
);

   import ks10Pkg::*;
   import aprPkg::*;

   logic [1:7] piReq;                   // Masked requests
   logic [1:7] piAct;                   // Active set
   level_t     reqPri;
   level_t     curPri;
   logic       intrNext;
   logic       ack;
   logic       dismiss;
   logic       clrAct;

   // Level 1 wins, 0 when nothing set
   function automatic level_t hiPri(input logic [1:7] v);
      level_t r;
      r = '0;
      for (int i = 7; i >= 1; i--) begin
         if (v[i])
            r = level_t'(i);
      end
      return r;
   endfunction

   ////////////////////////////////////////
   // Request arbitration
   ////////////////////////////////////////

   assign piReq  = (aprINTR | ubaINTR) & piEnable & {7{piOn}};
   assign reqPri = hiPri(piReq);
   assign curPri = hiPri(piAct);

   // Only strictly higher priority breaks in
   assign intrNext = (reqPri != '0) && ((curPri == '0) || (reqPri < curPri));

   ////////////////////////////////////////
   // Active level stack
   ////////////////////////////////////////

   assign ack     = uop.opStb && (uop.opFunc == opPIACK);
   assign dismiss = uop.opStb && (uop.opFunc == opPIDISMISS);
   assign clrAct  = uop.opStb && (uop.opFunc == opWRPI) && uop.opData[wrpiCLRACT];

   always_ff @(posedge clkT) begin
      if (rst) begin
         piAct    <= '0;
         piINTR   <= 1'b0;
         piREQPRI <= '0;
         piCURPRI <= '0;
      end else begin
         piINTR   <= intrNext;
         piREQPRI <= reqPri;
         piCURPRI <= curPri;
         if (clrAct)
            piAct <= '0;
         else if (ack && (piREQPRI != '0))
            piAct[piREQPRI] <= 1'b1;    // Push taken level
         else if (dismiss && (piCURPRI != '0))
            piAct[piCURPRI] <= 1'b0;    // Pop current level
      end
   end

   // An interrupt to the CPU always carries a level to acknowledge
   assert property (@(posedge clkT) disable iff (rst) piINTR |-> (piREQPRI != '0));

endmodule : pi

// ==== hdl/apr.sv ====
// Hardware events set flags even on a cycle where WRAPR clears them
module apr (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   uopIf.blk    uop,                    // Micro-op strobe
   input  logic timerINTR,              // Timer tick
   input  logic nxmINTR,                // NXM pulse
   input  logic cslINTRI,               // Console interrupt in
   output logic [aprPkg::aprFlagsFirst:aprPkg::aprFlagsLast] aprFLAGS,
   output logic [1:7] aprINTR,          // One-hot request at PIA
   output logic cslINTRO                // Interrupt to console
);

   import ks10Pkg::*;
   import aprPkg::*;

   flags_t aprFlg;                      // Flags
   flags_t aprEn;                       // Flag enables
   level_t aprPIA;                      // PI assignment
   flags_t hwSet;                       // Hardware set sources
   flags_t sel;                         // WRAPR flag select
   flags_t flgNext;
   flags_t enNext;
   logic   wrapr;
   logic   intrReq;

   assign wrapr = uop.opStb && (uop.opFunc == opWRAPR);
   assign sel   = uop.opData[wraprSelFirst:wraprSelLast];

   always_comb begin
      hwSet            = '0;                // No power-fail source here
      hwSet[flagNXM]   = nxmINTR;
      hwSet[flagTIMER] = timerINTR;
      hwSet[flagCSLI]  = cslINTRI;
   end

   ////////////////////////////////////////
   // Flag and enable update
   ////////////////////////////////////////

   always_comb begin
      flgNext = aprFlg;
      enNext  = aprEn;
      if (wrapr) begin
         if (uop.opData[wraprCLR])
            flgNext = flgNext & ~sel;
         if (uop.opData[wraprSET])
            flgNext = flgNext | sel;
         if (uop.opData[wraprEN])
            enNext = enNext | sel;
         if (uop.opData[wraprDIS])
            enNext = enNext & ~sel;
      end
      flgNext = flgNext | hwSet;           // Events always land
   end

   always_ff @(posedge clkT) begin
      if (rst) begin
         aprFlg <= '0;
         aprEn  <= '0;
         aprPIA <= '0;
      end else begin
         aprFlg <= flgNext;
         aprEn  <= enNext;
         if (wrapr)
            aprPIA <= uop.opData[wraprPiaFirst:wraprPiaLast];
      end
   end

   // CSLO goes to the console, not to the PI
   assign intrReq = |(aprFlg[flagPWR:flagCSLI] & aprEn[flagPWR:flagCSLI]);

   always_comb begin
      aprINTR = '0;
      if (aprPIA != '0)
         aprINTR[aprPIA] = intrReq;        // PIA 0 means unassigned
   end

   assign aprFLAGS[aprEnFirst:aprEnLast]   = aprEn;
   assign aprFLAGS[aprFlFirst:aprFlLast]   = aprFlg;
   assign aprFLAGS[aprIntrBit]             = intrReq;
   assign aprFLAGS[aprPiaFirst:aprPiaLast] = aprPIA;
   assign cslINTRO = aprFlg[flagCSLO];

   // PI sees at most one level from the APR
   assert property (@(posedge clkT) disable iff (rst) $onehot0(aprINTR));

endmodule : apr

// ==== hdl/timer.sv ====
// timerPeriod must be at least 2 and the count restarts whenever enable drops
module timer #(
   parameter int timerPeriod = 50       // Cycles between ticks
) (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   input  logic cslTIMEREN,             // Console timer enable
   output logic timerINTR               // One-cycle tick
);

   localparam int cntW = $clog2(timerPeriod);

   logic [cntW-1:0] tmrCnt;             // Prescale counter
   logic            tmrTC;              // Terminal count

   assign tmrTC = (tmrCnt == cntW'(timerPeriod - 1));

   always_ff @(posedge clkT) begin
      if (rst) begin
         tmrCnt    <= '0;
         timerINTR <= 1'b0;
      end else if (!cslTIMEREN) begin
         tmrCnt    <= '0;               // Held clear while off
         timerINTR <= 1'b0;
      end else if (tmrTC) begin
         tmrCnt    <= '0;
         timerINTR <= 1'b1;             // Tick and wrap
      end else begin
         tmrCnt    <= tmrCnt + 1'b1;
         timerINTR <= 1'b0;
      end
   end

endmodule : timer

// ==== hdl/intf.sv ====
// Console reset beats console set, and both beat the micro-op strobe
module intf (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   input  logic cslRESET,               // Console CPU reset
   input  logic cslSET,                 // Load RUN, EXEC, CONT
   input  logic cslRUN,                 // Run level
   input  logic cslCONT,                // Continue level
   input  logic cslEXEC,                // Execute level
   uopIf.blk    uop,                    // Micro-op strobe
   output logic cpuRUN,                 // Run status
   output logic cpuEXEC,                // Exec status
   output logic cpuCONT,                // Cont status
   output logic cpuHALT                 // Halt status
);

   import ks10Pkg::*;

   logic doHalt;
   logic doClrCont;

   assign doHalt    = uop.opStb && (uop.opFunc == opHALT);
   assign doClrCont = uop.opStb && (uop.opFunc == opCLRCONT);

   always_ff @(posedge clkT) begin
      if (rst || cslRESET) begin
         cpuRUN  <= 1'b0;
         cpuEXEC <= 1'b0;
         cpuCONT <= 1'b0;
         cpuHALT <= 1'b1;               // Come up halted
      end else if (cslSET) begin
         cpuRUN  <= cslRUN;
         cpuEXEC <= cslEXEC;
         cpuCONT <= cslCONT;
         if (cslRUN)
            cpuHALT <= 1'b0;
      end else if (doHalt) begin
         cpuRUN  <= 1'b0;
         cpuHALT <= 1'b1;
      end else if (doClrCont) begin
         cpuCONT <= 1'b0;               // Microcode consumed the step
         cpuEXEC <= 1'b0;
      end
   end

endmodule : intf

// ==== hdl/memBus.sv ====
// One read outstanding, and a read issued while cpuREQO is up is dropped
module memBus #(
   parameter int nxmTimeout = 16        // Cycles to wait for ACK
) (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   uopIf.blk    uop,                    // Micro-op strobe
   input  logic cpuACKI,                // Bus acknowledge
   output logic cpuREQO,                // Bus request
   output ks10Pkg::word_t cpuADDRO,     // Address and flags
   output logic nxmINTR                 // Timeout pulse
);

   import ks10Pkg::*;

   localparam int cntW = $clog2(nxmTimeout);

   logic            busRd;
   logic [cntW-1:0] nxmCnt;             // Watchdog

   assign busRd = uop.opStb && (uop.opFunc == opBUSRD);

   // Address register, loaded only when idle
   always_ff @(posedge clkT) begin
      if (busRd && !cpuREQO)
         cpuADDRO <= uop.opData;
   end

   always_ff @(posedge clkT) begin
      if (rst) begin
         cpuREQO <= 1'b0;
         nxmCnt  <= '0;
         nxmINTR <= 1'b0;
      end else begin
         nxmINTR <= 1'b0;
         if (!cpuREQO) begin
            nxmCnt <= '0;
            if (busRd)
               cpuREQO <= 1'b1;
         end else if (cpuACKI) begin
            cpuREQO <= 1'b0;            // Slave took it
         end else if (nxmCnt == cntW'(nxmTimeout - 1)) begin
            cpuREQO <= 1'b0;            // Nobody home
            nxmINTR <= 1'b1;
         end else begin
            nxmCnt <= nxmCnt + 1'b1;
         end
      end
   end

   assert property (@(posedge clkT) disable iff (rst) busRd |-> !cpuREQO);
   assert property (@(posedge clkT) disable iff (rst)
      cpuREQO && $past(cpuREQO) |-> $stable(cpuADDRO));

endmodule : memBus

// ==== hdl/cpuCtl.sv ====
// Microcode is replaced by the op strobe ports and every register runs on each clkT edge
module cpuCtl #(
   parameter int timerPeriod = 50,      // Timer tick period
   parameter int nxmTimeout  = 16       // Bus watchdog limit
) (
   input  logic clkT,                   // Clock
   input  logic rst,                    // Sync reset
   // Console
   input  logic cslRESET,               // CPU reset
   input  logic cslSET,                 // Set RUN, EXEC, CONT
   input  logic cslRUN,
   input  logic cslCONT,
   input  logic cslEXEC,
   input  logic cslTIMEREN,             // Timer enable
   input  logic cslINTRI,               // Console to CPU
   output logic cslINTRO,               // CPU to console
   // Unibus
   input  logic [1:7] ubaINTR,          // Unibus requests
   // Micro-op
   input  logic opStb,
   input  ks10Pkg::opFunc_t opFunc,
   input  ks10Pkg::word_t opData,
   // Bus
   input  logic cpuACKI,
   output logic cpuREQO,
   output ks10Pkg::word_t cpuADDRO,
   // Status
   output logic piINTR,
   output logic cpuHALT,
   output logic cpuRUN,
   output logic cpuEXEC,
   output logic cpuCONT,
   output logic [aprPkg::aprFlagsFirst:aprPkg::aprFlagsLast] aprFLAGS,
   output ks10Pkg::level_t piREQPRI,
   output ks10Pkg::level_t piCURPRI
);

   logic [1:7] aprINTR;                 // APR request, one-hot
   logic       piOn;
   logic [1:7] piEnable;
   logic       timerINTR;
   logic       nxmINTR;

   ////////////////////////////////////////
   // Micro-op distribution
   ////////////////////////////////////////

   uopIf uop ();

   // Sequencer side of the interface
   assign uop.opStb  = opStb;
   assign uop.opFunc = opFunc;
   assign uop.opData = opData;

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   apr uApr (
      .clkT(clkT), .rst(rst), .uop(uop.blk),
      .timerINTR(timerINTR), .nxmINTR(nxmINTR), .cslINTRI(cslINTRI),
      .aprFLAGS(aprFLAGS), .aprINTR(aprINTR), .cslINTRO(cslINTRO)
   );

   piCfg uPiCfg (
      .clkT(clkT), .rst(rst), .uop(uop.blk),
      .piOn(piOn), .piEnable(piEnable)
   );

   pi uPi (
      .clkT(clkT), .rst(rst), .uop(uop.blk),
      .piOn(piOn), .piEnable(piEnable), .aprINTR(aprINTR), .ubaINTR(ubaINTR),
      .piINTR(piINTR), .piREQPRI(piREQPRI), .piCURPRI(piCURPRI)
   );

   timer #(.timerPeriod(timerPeriod)) uTimer (
      .clkT(clkT), .rst(rst), .cslTIMEREN(cslTIMEREN), .timerINTR(timerINTR)
   );

   intf uIntf (
      .clkT(clkT), .rst(rst), .cslRESET(cslRESET), .cslSET(cslSET),
      .cslRUN(cslRUN), .cslCONT(cslCONT), .cslEXEC(cslEXEC), .uop(uop.blk),
      .cpuRUN(cpuRUN), .cpuEXEC(cpuEXEC), .cpuCONT(cpuCONT), .cpuHALT(cpuHALT)
   );

   memBus #(.nxmTimeout(nxmTimeout)) uMemBus (
      .clkT(clkT), .rst(rst), .uop(uop.blk), .cpuACKI(cpuACKI),
      .cpuREQO(cpuREQO), .cpuADDRO(cpuADDRO), .nxmINTR(nxmINTR)
   );

endmodule : cpuCtl

// ==== tests/tbCpuCtl.sv ====
// Runs the DUT with timerPeriod 20 and nxmTimeout 16, and each table row waits for its op to settle
module tbCpuCtl;

   import ks10Pkg::*;
   import aprPkg::*;

   localparam int clkPeriod = 4;
   localparam int tPeriod   = 20;          // Timer tick period for the DUT
   localparam int nxmLimit  = 16;          // Bus watchdog for the DUT
   localparam int maxRows   = 64;
   localparam int rowCycles = 16 + nxmLimit + 8;                  // Worst row incl. bus wait
   localparam int wdCycles  = maxRows * rowCycles + 8 * tPeriod + 100;

   logic clkT, rst;
   logic cslRESET, cslSET, cslRUN, cslCONT, cslEXEC, cslTIMEREN, cslINTRI, cslINTRO;
   logic [1:7] ubaINTR;
   logic opStb;
   opFunc_t opFunc;
   word_t opData;
   logic cpuACKI, cpuREQO;
   word_t cpuADDRO;
   logic piINTR, cpuHALT, cpuRUN, cpuEXEC, cpuCONT;
   logic [aprFlagsFirst:aprFlagsLast] aprFLAGS;
   level_t piREQPRI, piCURPRI;

   // One table row, stimulus first, expected outputs last
   typedef struct packed {
      opFunc_t      op;
      logic         stb;
      word_t        data;
      logic         cSet, cReset, cRun, cExec, cCont;
      logic [1:7]   uba;
      logic [3:0]   ackDly;                // Bus ACK delay in cycles
      logic         noAck;                 // Read runs into the watchdog
      logic [3:0]   waitCyc;
      logic         eRun, eExec, eCont, eHalt;
      logic [22:35] eFlags;
      logic         eCslo, eIntr;
      level_t       eReq, eCur;
   } row_t;

   row_t        tbl [maxRows];
   int          nRows = 0;
   int          errors = 0;
   int          nChecks = 0;
   string       stepTag = "init";
   logic [31:0] rngState = 32'd14382;

   // Reference model state
   logic       mRun, mExec, mCont, mHalt, mOn;
   flags_t     mFlg, mEn;
   level_t     mPia, mReq, mCur;
   logic [1:7] mEnable, mAct;

   cpuCtl #(.timerPeriod(tPeriod), .nxmTimeout(nxmLimit)) cpuCtl_i (.*);

   initial begin
      clkT = 1'b0;
      forever #(clkPeriod / 2) clkT = ~clkT;
   end

   initial begin
      #(wdCycles * clkPeriod);
      $display("Watchdog expired after %0d cycles, the run did not finish", wdCycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function logic [31:0] nextRand();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      nChecks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s %s: got 0x%0h, expected 0x%0h", stepTag, name, got, exp);
      end
   endtask

   function automatic logic [1:7] lv(input int n);
      logic [1:7] v;
      v    = '0;
      v[n] = 1'b1;
      return v;
   endfunction

   // First set level scanning from 1 upward
   function automatic level_t topLevel(input logic [1:7] v);
      level_t t;
      t = '0;
      for (int i = 1; i <= 7; i++)
         if (v[i] && t == '0) t = level_t'(i);
      return t;
   endfunction

   function automatic word_t wraprWord(input logic en, dis, clr, set, input flags_t sel,
                                       input level_t pia);
      word_t w;
      w = '0;
      w[wraprEN]  = en;
      w[wraprDIS] = dis;
      w[wraprCLR] = clr;
      w[wraprSET] = set;
      w[wraprSelFirst:wraprSelLast] = sel;
      w[wraprPiaFirst:wraprPiaLast] = pia;
      return w;
   endfunction

   function automatic word_t wrpiWord(input logic clrAct, lvlOff, lvlOn, sysOff, sysOn,
                                      input logic [1:7] sel);
      word_t w;
      w = '0;
      w[wrpiCLRACT] = clrAct;
      w[wrpiLVLOFF] = lvlOff;
      w[wrpiLVLON]  = lvlOn;
      w[wrpiSYSOFF] = sysOff;
      w[wrpiSYSON]  = sysOn;
      w[wrpiSelFirst:wrpiSelLast] = sel;
      return w;
   endfunction

   function automatic row_t mkRow(input opFunc_t op, input word_t data, input logic [1:7] uba);
      row_t r;
      r         = '0;
      r.op      = op;
      r.stb     = (op != opNOP);
      r.data    = data;
      r.uba     = uba;
      r.waitCyc = 4'd3;
      return r;
   endfunction

   ////////////////////////////////////////
   // Reference model, fills expected fields
   ////////////////////////////////////////

   task automatic pushRow(input row_t rIn);
      row_t       r;
      flags_t     sel, live;
      logic [1:7] lvlSel, aprReq;
      logic       aprIrq;
      r      = rIn;
      sel    = r.data[wraprSelFirst:wraprSelLast];
      lvlSel = r.data[wrpiSelFirst:wrpiSelLast];
      if (r.cReset) begin                  // Console reset wins
         {mRun, mExec, mCont, mHalt} = 4'b0001;
      end else if (r.cSet) begin
         {mRun, mExec, mCont} = {r.cRun, r.cExec, r.cCont};
         if (r.cRun) mHalt = 1'b0;
      end else if (r.stb && r.op == opHALT) begin
         mRun  = 1'b0;
         mHalt = 1'b1;
      end else if (r.stb && r.op == opCLRCONT) begin
         {mCont, mExec} = 2'b00;
      end
      if (r.stb && r.op == opWRAPR) begin
         if (r.data[wraprCLR]) mFlg &= ~sel; // Clear before set
         if (r.data[wraprSET]) mFlg |= sel;
         if (r.data[wraprEN])  mEn  |= sel;
         if (r.data[wraprDIS]) mEn  &= ~sel;
         mPia = r.data[wraprPiaFirst:wraprPiaLast];
      end
      if (r.stb && r.op == opBUSRD && r.noAck) mFlg[flagNXM] = 1'b1;
      if (r.stb && r.op == opWRPI) begin
         if (r.data[wrpiLVLON])  mEnable |= lvlSel;
         if (r.data[wrpiLVLOFF]) mEnable &= ~lvlSel;
         if (r.data[wrpiSYSOFF]) mOn = 1'b0;
         else if (r.data[wrpiSYSON]) mOn = 1'b1;
         if (r.data[wrpiCLRACT]) mAct = '0;
      end else if (r.stb && r.op == opPIACK && mReq != '0) begin
         mAct[mReq] = 1'b1;                // Takes the level seen before the op
      end else if (r.stb && r.op == opPIDISMISS && mCur != '0) begin
         mAct[mCur] = 1'b0;
      end
      live           = mFlg & mEn;
      live[flagCSLO] = 1'b0;               // Console flag never interrupts
      aprIrq         = |live;
      aprReq         = '0;
      if (mPia != '0) aprReq[mPia] = aprIrq;
      mReq = topLevel((aprReq | r.uba) & mEnable & {7{mOn}});
      mCur = topLevel(mAct);
      r.eIntr  = (mReq != '0) && (mCur == '0 || mReq < mCur);
      {r.eRun, r.eExec, r.eCont, r.eHalt} = {mRun, mExec, mCont, mHalt};
      r.eFlags = {mEn, mFlg, aprIrq, mPia};
      r.eCslo  = mFlg[flagCSLO];
      r.eReq   = mReq;
      r.eCur   = mCur;
      if (nRows < maxRows) begin
         tbl[nRows] = r;
         nRows++;
      end else begin
         errors++;
         $display("Stimulus table is full, a row was dropped");
      end
   endtask

   ////////////////////////////////////////
   // Row application
   ////////////////////////////////////////

   task automatic runBusRead(input row_t r);
      int n;
      check("cpuREQO", cpuREQO, 1'b1);     // Up the edge after the strobe
      check("cpuADDRO", cpuADDRO, r.data);
      if (!r.noAck) begin
         repeat (int'(r.ackDly)) @(negedge clkT);
         cpuACKI = 1'b1;
      end
      n = 0;
      while (cpuREQO && n < nxmLimit + 4) begin
         @(negedge clkT);
         n++;
      end
      cpuACKI = 1'b0;
      if (cpuREQO) begin
         errors++;
         $display("%s: bus request never dropped", stepTag);
      end else if (r.noAck) check("nxmWait", n, nxmLimit);
      else check("ackToDrop", n, 1);       // Drops on the next edge
   endtask

   task automatic applyRow(input row_t r);
      opStb    = r.stb;
      opFunc   = r.op;
      opData   = r.data;
      cslSET   = r.cSet;
      cslRESET = r.cReset;
      cslRUN   = r.cRun;
      cslEXEC  = r.cExec;
      cslCONT  = r.cCont;
      ubaINTR  = r.uba;
      @(negedge clkT);
      opStb    = 1'b0;                     // Strobes last one cycle
      opFunc   = opNOP;
      cslSET   = 1'b0;
      cslRESET = 1'b0;
      if (r.stb && r.op == opBUSRD) runBusRead(r);
      repeat (int'(r.waitCyc) - 1) @(negedge clkT);
      check("cpuRUN", cpuRUN, r.eRun);
      check("cpuEXEC", cpuEXEC, r.eExec);
      check("cpuCONT", cpuCONT, r.eCont);
      check("cpuHALT", cpuHALT, r.eHalt);
      check("aprFLAGS", aprFLAGS, r.eFlags);
      check("cslINTRO", cslINTRO, r.eCslo);
      check("piINTR", piINTR, r.eIntr);
      check("piREQPRI", piREQPRI, r.eReq);
      check("piCURPRI", piCURPRI, r.eCur);
      check("cpuREQO", cpuREQO, 1'b0);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      row_t        r;
      logic [31:0] rnd;
      int          n;
      rst = 1'b1;
      {cslRESET, cslSET, cslRUN, cslCONT, cslEXEC, cslTIMEREN, cslINTRI} = '0;
      {opStb, cpuACKI} = 2'b00;
      ubaINTR = '0;
      opFunc  = opNOP;
      opData  = '0;
      {mRun, mExec, mCont, mHalt, mOn} = 5'b00010;       // Comes up halted
      {mFlg, mEn, mPia, mReq, mCur, mEnable, mAct} = '0;

      // Console sequence
      pushRow(mkRow(opNOP, '0, '0));                     // Reset values
      r = mkRow(opNOP, '0, '0);
      {r.cSet, r.cRun, r.cExec, r.cCont} = 4'b1111;
      pushRow(r);
      pushRow(mkRow(opCLRCONT, '0, '0));
      pushRow(mkRow(opHALT, '0, '0));
      r = mkRow(opNOP, '0, '0);
      {r.cSet, r.cRun} = 2'b11;
      pushRow(r);
      r = mkRow(opNOP, '0, '0);
      r.cReset = 1'b1;
      pushRow(r);

      // APR flags, order CSLO PWR NXM TIMER CSLI
      pushRow(mkRow(opWRAPR, wraprWord(1, 0, 0, 0, 5'b00111, 3'd3), '0));
      pushRow(mkRow(opWRAPR, wraprWord(0, 0, 0, 1, 5'b10001, 3'd3), '0));
      pushRow(mkRow(opWRAPR, wraprWord(0, 0, 1, 0, 5'b10000, 3'd3), '0));
      pushRow(mkRow(opWRAPR, wraprWord(0, 1, 0, 0, 5'b00001, 3'd3), '0));
      pushRow(mkRow(opWRAPR, wraprWord(0, 0, 0, 1, 5'b01000, 3'd5), '0));
      pushRow(mkRow(opWRAPR, wraprWord(0, 0, 1, 0, 5'b11111, 3'd0), '0));

      // PI priority, random masks and requests
      pushRow(mkRow(opWRPI, wrpiWord(0, 0, 1, 0, 1, 7'b1010101), 7'b0111110));
      for (int k = 0; k < 8; k++) begin
         rnd = nextRand();
         pushRow(mkRow(opWRPI, wrpiWord(0, rnd[0], rnd[1], rnd[2] & rnd[3], rnd[4],
                                        rnd[14:8]), rnd[22:16]));
         pushRow(mkRow(opNOP, '0, rnd[30:24]));          // Same masks, new requests
      end
      pushRow(mkRow(opWRPI, wrpiWord(0, 0, 0, 1, 0, '0), 7'b1111111));

      // Acknowledge and dismiss nesting
      pushRow(mkRow(opWRPI, wrpiWord(1, 0, 1, 0, 1, 7'b1111111), '0));
      pushRow(mkRow(opNOP, '0, lv(5)));
      pushRow(mkRow(opPIACK, '0, lv(5)));
      pushRow(mkRow(opNOP, '0, lv(5) | lv(6)));          // Lower level waits
      pushRow(mkRow(opNOP, '0, lv(5) | lv(2)));
      pushRow(mkRow(opPIACK, '0, lv(5) | lv(2)));
      pushRow(mkRow(opNOP, '0, lv(4) | lv(2)));          // Equal level waits
      pushRow(mkRow(opPIDISMISS, '0, lv(4)));
      pushRow(mkRow(opPIDISMISS, '0, '0));

      // Bus reads, NXM lands at PIA 4
      pushRow(mkRow(opWRAPR, wraprWord(1, 0, 0, 0, 5'b00100, 3'd4), '0));
      for (int k = 0; k < 3; k++) begin
         r        = mkRow(opBUSRD, {4'h0, nextRand()}, '0);
         r.ackDly = 4'(nextRand() & 32'h7);
         pushRow(r);
      end
      r         = mkRow(opBUSRD, {4'h5, nextRand()}, '0);
      r.noAck   = 1'b1;
      r.waitCyc = 4'd4;                    // NXM pulse then flag then PI
      pushRow(r);
      pushRow(mkRow(opWRAPR, wraprWord(0, 0, 1, 0, 5'b00100, 3'd0), '0));

      repeat (8) @(posedge clkT);
      @(negedge clkT);
      rst = 1'b0;
      for (int i = 0; i < nRows; i++) begin
         stepTag = $sformatf("row %0d", i);
         applyRow(tbl[i]);
      end

      // Timer, quiet while off then one tick
      stepTag = "timer off";
      repeat (3 * tPeriod) begin
         @(negedge clkT);
         check("flagTIMER", aprFLAGS[aprFlFirst + flagTIMER], 1'b0);
      end
      stepTag    = "timer on";
      cslTIMEREN = 1'b1;
      n = 0;
      while (!aprFLAGS[aprFlFirst + flagTIMER] && n < tPeriod + 2) begin
         @(negedge clkT);
         n++;
      end
      check("flagTIMER", aprFLAGS[aprFlFirst + flagTIMER], 1'b1);
      cslTIMEREN = 1'b0;

      $display("Checks run: %0d, errors: %0d", nChecks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule : tbCpuCtl

// ==== vlog.f ====
common/ks10Pkg.sv
common/aprPkg.sv
common/uopIf.sv
pi/piCfg.sv
pi/pi.sv
hdl/apr.sv
hdl/timer.sv
hdl/intf.sv
hdl/memBus.sv
hdl/cpuCtl.sv
tests/tbCpuCtl.sv

// ==== Makefile ====
# Verilator build and run for the cpuCtl testbench

VERILATOR ?= verilator
TOP       ?= tbCpuCtl
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
